/* noise_chan_pkg.sv */
`default_nettype none

package noise_chan_pkg;

    // widths with a meaning of their own
    typedef logic [4:0]  nfrq_t;      // noise frequency code
    typedef logic [9:0]  eg_t;        // envelope attenuation, 0 = loudest
    typedef logic [11:0] mix_t;       // noise mix, sign on top
    typedef logic [11:0] sample_t;    // slot output, same format as mix_t
    typedef logic [4:0]  slot_t;      // operator slot number
    typedef logic [7:0]  reg_addr_t;  // register bus address
    typedef logic [7:0]  reg_data_t;  // register bus data

    // register map, only the noise register is kept
    // bit 7 enables noise on slot 31, bits 4..0 hold nfrq
    localparam reg_addr_t NOISE_ADDR = 8'h0f;

    // LFSR comes out of reset all ones
    localparam logic [15:0] LFSR_RESET = 16'hffff;

    // slot timing
    localparam slot_t SLOT_LAST = 5'd31;  // last operator slot, noise slot
    localparam slot_t HALF_SLOT = 5'd15;  // half tick here and at SLOT_LAST

endpackage

`default_nettype wire

/* noise_timing.sv */
`timescale 1ns/1ps
`default_nettype none

// operator slot sequencer for the noise channel
// one slot per clock enable, 32 slots per frame
module noise_timing (
    input  wire logic                 clk,
    input  wire logic                 rst,
    input  wire logic                 cen,      // chip clock enable
    output      noise_chan_pkg::slot_t slot,    // current operator slot
    output      logic                 half,     // once every 16 enables
    output      logic                 op31_no   // slot 31 strobe
);

    logic slot_is_half;  // slot 15
    logic slot_is_last;  // slot 31

    // slot counter, wraps 31 -> 0 on its own width
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            slot <= '0;
        end else if (cen) begin
            slot <= slot + 5'd1;
        end
    end

    // decodes of the current slot
    assign slot_is_half = (slot == noise_chan_pkg::HALF_SLOT);
    assign slot_is_last = (slot == noise_chan_pkg::SLOT_LAST);

    // ticks are qualified by cen so each lasts a single clock
    // half at 15 and 31 gives one tick per 16 enables
    assign half    = cen & (slot_is_half | slot_is_last);
    assign op31_no = cen & slot_is_last;  // last slot, noise is mixed here

endmodule

`default_nettype wire

/* noise_regs.sv */
`timescale 1ns/1ps
`default_nettype none

// noise control register
// write only, nothing reads it back
module noise_regs (
    input  wire logic                      clk,
    input  wire logic                      rst,
    input  wire logic                      wr,    // write strobe
    input  wire noise_chan_pkg::reg_addr_t addr,  // register address
    input  wire noise_chan_pkg::reg_data_t din,   // write data
    output      logic                      ne,    // noise enable
    output      noise_chan_pkg::nfrq_t     nfrq   // noise frequency code
);

    logic hit;  // write lands on the noise register

    // other addresses belong to blocks outside this channel
    assign hit = wr & (addr == noise_chan_pkg::NOISE_ADDR);

    // writes do not wait for cen, the bus runs at full clock
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ne   <= 1'b0;
            nfrq <= '0;
        end else if (hit) begin
            ne   <= din[7];    // enable bit
            nfrq <= din[4:0];  // frequency code, bits 6..5 unused
        end
    end

endmodule

`default_nettype wire

/* noise_gen.sv */
`timescale 1ns/1ps
`default_nettype none

// noise generator for slot 31
// period counter, 16-bit LFSR and the envelope-weighted mix
module noise_gen (
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire logic                  cen,      // chip clock enable
    input  wire logic                  half,     // once every 16 enables
    input  wire noise_chan_pkg::nfrq_t nfrq,     // noise frequency code
    input  wire noise_chan_pkg::eg_t   eg,       // slot 31 attenuation
    input  wire logic                  op31_no,  // slot 31 strobe
    output      logic                  noise,    // LFSR output bit
    output      noise_chan_pkg::mix_t  mix       // noise mix sample
);

    noise_chan_pkg::nfrq_t cnt;  // half tick counter
    logic        update;         // registered period match
    logic [15:0] lfsr;
    logic        last_lfsr0;     // inverted bit 0, kept from last update
    logic        nfrq_met;
    logic        all1;           // LFSR stuck at all ones
    logic        fb;             // feedback into bit 15
    logic        mix_sgn;

    assign noise = lfsr[0];

    // period counter
    // the code is used inverted, so nfrq 31 runs fastest
    assign nfrq_met = (cnt == ~nfrq);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cnt    <= '0;
            update <= 1'b0;
        end else if (cen) begin
            if (half) begin
                cnt <= nfrq_met ? 5'd0 : cnt + 5'd1;
            end
            update <= nfrq_met;  // one enable behind the match
        end
    end

    // LFSR feedback
    // between updates the bit is just inverted, which doubles the rate
    // on update the tap of bit 2 runs against the stored bit
    assign all1 = &lfsr;
    assign fb   = update ? ((all1 & ~last_lfsr0) | (lfsr[2] ^ last_lfsr0))
                         : ~lfsr[0];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            lfsr       <= noise_chan_pkg::LFSR_RESET;
            last_lfsr0 <= 1'b0;  // matches ~lfsr[0] of the reset value
        end else if (cen) begin
            lfsr <= {fb, lfsr[15:1]};  // shift right
            if (update) begin
                last_lfsr0 <= ~lfsr[0];
            end
        end
    end

    // noise mix
    // zero attenuation keeps the sign clear via the eg check below
    assign mix_sgn = (eg != '0) & ~noise;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            mix <= '0;
        end else if (cen && op31_no) begin
            // sign, inverted attenuation flipped by noise, sign fill
            mix <= {mix_sgn, ~eg[9:2] ^ {8{~noise}}, {3{mix_sgn}}};
        end
    end

endmodule

`default_nettype wire

/* noise_slot_out.sv */
`timescale 1ns/1ps
`default_nettype none

// slot 31 output stage
// noise replaces the operator when enabled
module noise_slot_out (
    input  wire logic                    clk,
    input  wire logic                    rst,
    input  wire logic                    cen,         // chip clock enable
    input  wire logic                    op31_no,     // slot 31 strobe
    input  wire logic                    ne,          // noise enable
    input  wire noise_chan_pkg::mix_t    mix,         // noise mix
    input  wire noise_chan_pkg::sample_t op_sample,   // slot 31 operator
    output      noise_chan_pkg::sample_t slot_out,    // latched sample
    output      logic                    slot_valid   // new slot_out
);

    logic                    load;  // latch edge
    noise_chan_pkg::sample_t sel;   // source picked for this frame

    assign load = cen & op31_no;

    // mix is still the one formed a frame ago at this edge
    assign sel = ne ? mix : op_sample;

    // held for the whole frame, no back-pressure
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            slot_out   <= '0;
            slot_valid <= 1'b0;
        end else begin
            slot_valid <= load;  // one clock, marks the load
            if (load) begin
                slot_out <= sel;
            end
        end
    end

endmodule

`default_nettype wire

/* noise_chan_top.sv */
`timescale 1ns/1ps
`default_nettype none

// noise channel of the FM generator
// timing, register, generator and slot 31 output
module noise_chan_top (
    input  wire logic                      clk,
    input  wire logic                      rst,
    input  wire logic                      cen,         // chip clock enable
    input  wire logic                      wr,          // register write
    input  wire noise_chan_pkg::reg_addr_t addr,
    input  wire noise_chan_pkg::reg_data_t din,
    input  wire noise_chan_pkg::eg_t       eg,          // slot 31 envelope
    input  wire noise_chan_pkg::sample_t   op_sample,   // slot 31 operator
    output      logic                      noise,       // LFSR bit
    output      noise_chan_pkg::sample_t   slot_out,
    output      logic                      slot_valid
);

    logic                  half;
    logic                  op31_no;
    logic                  ne;
    noise_chan_pkg::nfrq_t nfrq;
    noise_chan_pkg::mix_t  mix;

    noise_timing u_timing (
        .clk     (clk),
        .rst     (rst),
        .cen     (cen),
        .slot    (),
        .half    (half),
        .op31_no (op31_no)
    );

    noise_regs u_regs (
        .clk  (clk),
        .rst  (rst),
        .wr   (wr),
        .addr (addr),
        .din  (din),
        .ne   (ne),
        .nfrq (nfrq)
    );

    noise_gen u_gen (
        .clk     (clk),
        .rst     (rst),
        .cen     (cen),
        .half    (half),
        .nfrq    (nfrq),
        .eg      (eg),
        .op31_no (op31_no),
        .noise   (noise),
        .mix     (mix)
    );

    noise_slot_out u_slot_out (
        .clk        (clk),
        .rst        (rst),
        .cen        (cen),
        .op31_no    (op31_no),
        .ne         (ne),
        .mix        (mix),
        .op_sample  (op_sample),
        .slot_out   (slot_out),
        .slot_valid (slot_valid)
    );

endmodule

`default_nettype wire

/* noise_chan_chk.sv */
`timescale 1ns/1ps
`default_nettype none

// timing and output properties of the noise channel
module noise_chan_chk (
    input wire logic clk,
    input wire logic rst,
    input wire logic cen,
    input wire logic half,
    input wire logic op31_no,
    input wire logic slot_valid
);

    int fail_count = 0;  // failed assertions so far

    // ticks only on enabled clocks
    a_half_cen: assert property (@(posedge clk) disable iff (rst) half |-> cen)
        else begin
            $error("half tick without cen");
            fail_count++;
        end
    a_op31_cen: assert property (@(posedge clk) disable iff (rst) op31_no |-> cen)
        else begin
            $error("slot 31 strobe without cen");
            fail_count++;
        end

    // slot 31 is also a half slot
    a_op31_half: assert property (@(posedge clk) disable iff (rst) op31_no |-> half)
        else begin
            $error("slot 31 strobe without half tick");
            fail_count++;
        end

    // valid comes right after the strobe for a single clock
    a_valid_next: assert property (@(posedge clk) disable iff (rst) op31_no |=> slot_valid)
        else begin
            $error("slot_valid missing after slot 31 strobe");
            fail_count++;
        end
    a_valid_src: assert property (@(posedge clk) disable iff (rst)
                                  slot_valid |-> $past(op31_no))
        else begin
            $error("slot_valid without slot 31 strobe");
            fail_count++;
        end
    a_valid_one: assert property (@(posedge clk) disable iff (rst) slot_valid |=> !slot_valid)
        else begin
            $error("slot_valid longer than one clock");
            fail_count++;
        end

endmodule

bind noise_chan_top noise_chan_chk u_chk (
    .clk        (clk),
    .rst        (rst),
    .cen        (cen),
    .half       (half),
    .op31_no    (op31_no),
    .slot_valid (slot_valid)
);

`default_nettype wire

/* noise_chan_tb.sv */
`timescale 1ns/1ps
`default_nettype none

// testbench for the noise channel
// random stimulus checked each clock against a cycle model
module noise_chan_tb;

    localparam int RESET_CYCLES = 8;
    localparam int LFSR_CYCLES  = 6000;  // about 3000 enables
    localparam int PERIOD_MAX   = 3000;  // bound per nfrq value
    localparam int PERIOD_TAIL  = 500;   // run after the mid-run rewrite
    localparam int MIX_CYCLES   = 3000;
    localparam int EN_CYCLES    = 3000;
    localparam int DEC_CYCLES   = 2000;
    localparam int TEST_CYCLES  = RESET_CYCLES + LFSR_CYCLES + 3 * PERIOD_MAX
                                  + PERIOD_TAIL + MIX_CYCLES + EN_CYCLES + DEC_CYCLES;
    localparam int CYCLE_LIMIT  = 2 * TEST_CYCLES;

    logic                      clk;
    logic                      rst;
    logic                      cen;
    logic                      wr;
    noise_chan_pkg::reg_addr_t addr;
    noise_chan_pkg::reg_data_t din;
    noise_chan_pkg::eg_t       eg;
    noise_chan_pkg::sample_t   op_sample;
    logic                      noise;
    noise_chan_pkg::sample_t   slot_out;
    logic                      slot_valid;

    // cycle model state
    logic [4:0]  m_slot;
    logic [4:0]  m_cnt;        // half tick counter
    logic        m_update;
    logic [15:0] m_lfsr;
    logic        m_last0;      // stored inverted bit 0
    logic [11:0] m_mix;
    logic [11:0] m_out;
    logic        m_valid;
    logic        m_ne;
    logic [4:0]  m_nfrq;
    int          m_halves;     // half ticks since last match
    int          m_clears;     // period matches so far
    int          last_period;  // half ticks between the last two matches

    integer seed = 32'hb77c;
    logic   eg_zero;           // eg drops to zero now and then
    string  cur_test;
    int     checks = 0;
    int     errors = 0;
    int     test_err0;
    int     tests_run = 0;
    int     tests_failed = 0;
    int     cycles = 0;

    noise_chan_top u_noise_chan_top (
        .clk        (clk),
        .rst        (rst),
        .cen        (cen),
        .wr         (wr),
        .addr       (addr),
        .din        (din),
        .eg         (eg),
        .op_sample  (op_sample),
        .noise      (noise),
        .slot_out   (slot_out),
        .slot_valid (slot_valid)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;  // 8 ns period

    // run limit
    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Test FAILED");
            $finish;
        end
    end

    task automatic check_value(input string what, input logic [15:0] expected,
                               input logic [15:0] actual);
        checks++;
        assert (actual === expected) else begin
            $display("ERROR %s %s expected %0h actual %0h", cur_test, what, expected, actual);
            errors++;
        end
    endtask

    task automatic model_reset;
        m_slot      = '0;
        m_cnt       = '0;
        m_update    = 1'b0;
        m_lfsr      = 16'hffff;  // all ones out of reset
        m_last0     = 1'b0;
        m_mix       = '0;
        m_out       = '0;
        m_valid     = 1'b0;
        m_ne        = 1'b0;
        m_nfrq      = '0;
        m_halves    = 0;
        m_clears    = 0;
        last_period = 0;
    endtask

    // one clock edge of the model on the inputs the DUT sees at this edge
    task automatic model_update;
        logic        tick_half;
        logic        tick_last;
        logic        met;
        logic        fb;
        logic        sgn;
        logic [7:0]  mag;
        logic [11:0] formed;
        tick_half = cen && (m_slot == 5'd15 || m_slot == 5'd31);
        tick_last = cen && (m_slot == 5'd31);
        met       = (m_cnt == 5'd31 - m_nfrq);  // code counts inverted
        // feedback into the top bit
        if (!m_update) begin
            fb = !m_lfsr[0];
        end else if (m_lfsr == 16'hffff && !m_last0) begin
            fb = 1'b1;  // stuck escape
        end else begin
            fb = m_lfsr[2] ^ m_last0;
        end
        // mix from the noise bit before the edge
        sgn    = (eg != 10'd0) && !m_lfsr[0];
        mag    = m_lfsr[0] ? ~eg[9:2] : eg[9:2];
        formed = {sgn, mag, sgn, sgn, sgn};
        // output stage sees last frame's mix
        m_valid = tick_last;
        if (tick_last) begin
            m_out = m_ne ? m_mix : op_sample;
        end
        if (cen) begin
            if (tick_last) begin
                m_mix = formed;
            end
            if (m_update) begin
                m_last0 = !m_lfsr[0];
            end
            m_lfsr   = {fb, m_lfsr[15:1]};
            m_update = met;
            if (tick_half) begin
                m_halves++;
                if (met) begin
                    last_period = m_halves;
                    m_halves    = 0;
                    m_clears++;
                    m_cnt = '0;
                end else begin
                    m_cnt = m_cnt + 5'd1;
                end
            end
            m_slot = m_slot + 5'd1;  // wraps at 32
        end
        // register write regardless of cen
        if (wr && addr == noise_chan_pkg::NOISE_ADDR) begin
            m_ne   = din[7];
            m_nfrq = din[4:0];
        end
    endtask

    // model step and new inputs on the rising edge then compare at the falling edge
    task automatic clock_step(input logic w, input noise_chan_pkg::reg_addr_t a,
                              input noise_chan_pkg::reg_data_t d);
        logic [31:0] r1;
        logic [31:0] r2;
        @(posedge clk);
        model_update();
        r1 = $random(seed);
        r2 = $random(seed);
        cen  <= r1[0];  // enabled on about half the clocks
        wr   <= w;
        addr <= a;
        din  <= d;
        if (eg_zero && r1[3:2] == 2'b00) begin
            eg <= '0;
        end else begin
            eg <= r1[13:4];
        end
        op_sample <= r2[11:0];
        @(negedge clk);
        check_value("noise", m_lfsr[0], noise);
        check_value("slot_valid", m_valid, slot_valid);
        check_value("slot_out", m_out, slot_out);
    endtask

    task automatic start_test(input string name);
        cur_test  = name;
        test_err0 = errors;
    endtask

    task automatic finish_test;
        tests_run++;
        if (errors == test_err0) begin
            $display("%-8s passed", cur_test);
        end else begin
            tests_failed++;
            $display("%-8s failed, %0d errors", cur_test, errors - test_err0);
        end
    endtask

    initial begin
        logic [31:0]               r;
        noise_chan_pkg::reg_addr_t a;
        int                        nf;
        int                        c0;
        int                        n;
        int                        seen;
        logic                      ne_v;
        rst       = 1'b1;
        cen       = 1'b0;
        wr        = 1'b0;
        addr      = '0;
        din       = '0;
        eg        = '0;
        op_sample = '0;
        eg_zero   = 1'b0;
        model_reset();
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;

        start_test("reset");
        @(negedge clk);
        check_value("noise", 16'd1, noise);
        check_value("slot_out", 16'd0, slot_out);
        check_value("slot_valid", 16'd0, slot_valid);
        finish_test();

        // rare random writes with half of them off the noise address
        start_test("lfsr");
        for (int i = 0; i < LFSR_CYCLES; i++) begin
            r = $random(seed);
            if (r[5:0] == 6'd0) begin
                clock_step(1'b1, r[6] ? noise_chan_pkg::NOISE_ADDR : r[15:8], r[23:16]);
            end else begin
                clock_step(1'b0, '0, '0);
            end
        end
        finish_test();

        start_test("period");
        for (int k = 0; k < 3; k++) begin
            nf = (k == 0) ? 31 : (k == 1) ? 28 : 22;
            clock_step(1'b1, noise_chan_pkg::NOISE_ADDR, {3'b000, nf[4:0]});
            c0 = m_clears;
            n  = 0;
            while (m_clears < c0 + 4 && n < PERIOD_MAX) begin
                seen = m_clears;
                clock_step(1'b0, '0, '0);
                n++;
                // first match may still run on the old code
                if (m_clears != seen && m_clears >= c0 + 2) begin
                    check_value("period", 32 - nf, last_period);
                end
            end
            assert (m_clears >= c0 + 4) else begin
                $display("period: too few period matches for nfrq %0d", nf);
                errors++;
            end
        end
        for (int i = 0; i < PERIOD_TAIL; i++) begin
            r = $random(seed);
            clock_step(i == 100, noise_chan_pkg::NOISE_ADDR, r[7:0]);  // mid-run rewrite
        end
        finish_test();

        start_test("mix");
        eg_zero = 1'b1;
        seen    = 0;
        r       = $random(seed);
        clock_step(1'b1, noise_chan_pkg::NOISE_ADDR, {3'b100, r[4:0]});
        for (int i = 0; i < MIX_CYCLES; i++) begin
            clock_step(1'b0, '0, '0);
            if (slot_valid) begin
                seen++;
            end
        end
        assert (seen > 0) else begin
            $display("mix: no slot_valid pulse seen");
            errors++;
        end
        eg_zero = 1'b0;
        finish_test();

        // enable flips every 250 clocks starting disabled
        start_test("enable");
        ne_v = 1'b0;
        for (int i = 0; i < EN_CYCLES; i++) begin
            r = $random(seed);
            if (i % 250 == 0) begin
                clock_step(1'b1, noise_chan_pkg::NOISE_ADDR, {ne_v, 2'b00, r[4:0]});
                ne_v = ~ne_v;
            end else begin
                clock_step(1'b0, '0, '0);
            end
        end
        finish_test();

        start_test("decode");
        r = $random(seed);
        clock_step(1'b1, noise_chan_pkg::NOISE_ADDR, {3'b100, r[4:0]});
        for (int i = 0; i < DEC_CYCLES; i++) begin
            r = $random(seed);
            a = r[7:0];
            if (a == noise_chan_pkg::NOISE_ADDR) begin
                a = a + 8'd1;  // always a miss
            end
            clock_step(r[9:8] != 2'b00, a, r[23:16]);
        end
        finish_test();

        $display("tests %0d, failed %0d, checks %0d, errors %0d, assertion failures %0d",
                 tests_run, tests_failed, checks, errors,
                 u_noise_chan_top.u_chk.fail_count);
        if (errors == 0 && u_noise_chan_top.u_chk.fail_count == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* noise_chan.f */
noise_chan_pkg.sv
noise_timing.sv
noise_regs.sv
noise_gen.sv
noise_slot_out.sv
noise_chan_top.sv
noise_chan_chk.sv
noise_chan_tb.sv

/* Bender.yml */
package:
  name: noise_chan

sources:
  - files:
      - noise_chan_pkg.sv
      - noise_timing.sv
      - noise_regs.sv
      - noise_gen.sv
      - noise_slot_out.sv
      - noise_chan_top.sv
  - target: test
    files:
      - noise_chan_chk.sv
      - noise_chan_tb.sv
